// ==== compile.f ====
+incdir+verilog
verilog/audio_pkg.sv
verilog/seq_tick_if.sv
verilog/frame_sequencer.sv
verilog/power_ctrl.sv
verilog/square_channel.sv
verilog/direct_sound_fifo.sv
verilog/audio_mixer.sv
verilog/audio_top.sv
verification/tb_audio_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the audio testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_audio_top -f compile.f \
    -Mdir obj_dir -o tb_audio_top > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_audio_top > sim.log 2>&1 \
    || { echo "simulator exited with an error, see sim.log"; exit 1; }
grep -q "=== FAIL ===" sim.log \
    && { echo "simulation failed, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== verification/tb_audio_top.sv ====
`timescale 1ns/1ps
`include "audio_settings.svh"

module tb_audio_top;

    import audio_pkg::*;

    localparam int NUM_TESTS     = 11;
    localparam int VALID_LATENCY = 2;

    typedef struct packed {
        logic       master_en;
        logic       trigger;
        duty_e      duty;
        logic [5:0] period;
        logic [5:0] length;
        logic       length_en;
        logic [3:0] volume;
        logic       env_up;
        logic [2:0] env_pace;
        logic [3:0] pan;
        logic       ds_half;
        logic [3:0] n_wr;
        logic       pwr_down;
        logic [7:0] n_ticks;
    } test_row_t;

    logic        clk_100 = 1'b0;
    logic        arst_n;
    logic        master_en;
    logic        sq_trigger;
    duty_e       sq_duty;
    logic [5:0]  sq_period;
    logic [5:0]  sq_length;
    logic        sq_length_en;
    sq_level_t   sq_volume;
    logic        sq_env_up;
    logic [2:0]  sq_env_pace;
    logic        pan_sq_l;
    logic        pan_sq_r;
    logic        pan_ds_l;
    logic        pan_ds_r;
    logic        ds_half;
    logic        fifo_wr_valid;
    ds_sample_t  fifo_wr_data;
    logic        fifo_credit;
    mix_sample_t audio_l;
    mix_sample_t audio_r;
    logic        audio_valid;

    test_row_t   tests [NUM_TESTS];
    string       names [NUM_TESTS];
    logic        table_ready = 1'b0;
    logic [31:0] rng = 32'd44;
    int          errors = 0;
    int          test_errors = 0;
    int          failed_tests = 0;
    int          credits_spent = 0;
    int          credits_returned = 0;
    // cycles since reset release
    int          cycle_cnt = 0;

    // reference model state
    int               k_tick = 0;
    logic             m_pwr = 1'b0;
    logic             m_active;
    logic [2:0]       m_step;
    int               m_period_cnt;
    int               m_len;
    int               m_vol;
    int               m_env_cnt;
    logic signed [7:0] m_ds;
    logic [7:0]       m_queue [$];
    int               exp_l;
    int               exp_r;

    audio_top dut (.*);

    always #2 clk_100 = ~clk_100;

    always @(negedge clk_100) begin
        if (arst_n && fifo_credit) begin
            credits_returned++;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int credits_free();
        return `AUD_FIFO_DEPTH - credits_spent + credits_returned;
    endfunction

    // high steps of each duty pattern
    function automatic logic pattern_high(input duty_e d, input logic [2:0] s);
        case (d)
            DUTY_12: return s == 3'd7;
            DUTY_25: return s >= 3'd6;
            DUTY_50: return s >= 3'd4;
            default: return s < 3'd6;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%0h expected 0x%0h at sample %0d",
                     name, actual, expected, k_tick);
            errors++;
            test_errors++;
        end
    endtask

    task automatic step_cycle();
        @(posedge clk_100);
        #0.5;
        cycle_cnt++;
    endtask

    // valid follows each sample tick by a fixed latency
    task automatic wait_valid();
        step_cycle();
        while (!audio_valid) begin
            step_cycle();
        end
        check_value("audio_valid cycle", cycle_cnt,
                    (k_tick + 1) * `AUD_SAMPLE_DIV + VALID_LATENCY);
    endtask

    task automatic model_clear();
        m_active     = 1'b0;
        m_step       = 3'd0;
        m_period_cnt = 0;
        m_len        = 0;
        m_vol        = 0;
        m_env_cnt    = 0;
        m_ds         = '0;
    endtask

    task automatic model_tick();
        logic len_tick;
        logic env_tick;
        int   sq_term;
        int   ds_term;
        k_tick++;
        // length ticks on even sequencer steps and envelope ticks on step 7
        len_tick = (k_tick % `AUD_STEP_SAMPLES == 0) && ((k_tick / `AUD_STEP_SAMPLES) % 2 == 0);
        env_tick = (k_tick % `AUD_STEP_SAMPLES == 0) && ((k_tick / `AUD_STEP_SAMPLES) % 8 == 7);
        if (!m_pwr) begin
            model_clear();
        end else begin
            if (m_period_cnt == 0) begin
                m_period_cnt = sq_period;
                m_step++;
            end else begin
                m_period_cnt--;
            end
            if (len_tick && sq_length_en && m_active && (m_len != 0)) begin
                m_len--;
                if (m_len == 0) begin
                    m_active = 1'b0;
                end
            end
            if (env_tick && (sq_env_pace != 0)) begin
                if (m_env_cnt == sq_env_pace - 1) begin
                    m_env_cnt = 0;
                    if (sq_env_up && (m_vol < 15)) begin
                        m_vol++;
                    end else if (!sq_env_up && (m_vol > 0)) begin
                        m_vol--;
                    end
                end else begin
                    m_env_cnt++;
                end
            end
            if (m_queue.size() > 0) begin
                m_ds = m_queue.pop_front();
            end
        end
        sq_term = (m_active && pattern_high(sq_duty, m_step)) ? m_vol * 4 : 0;
        ds_term = ds_half ? (int'(m_ds) >>> 1) : int'(m_ds);
        exp_l = (pan_sq_l ? sq_term : 0) + (pan_ds_l ? ds_term : 0);
        exp_r = (pan_sq_r ? sq_term : 0) + (pan_ds_r ? ds_term : 0);
    endtask

    task automatic check_outputs();
        check_value("audio_l", {22'd0, audio_l}, {22'd0, exp_l[9:0]});
        check_value("audio_r", {22'd0, audio_r}, {22'd0, exp_r[9:0]});
    endtask

    task automatic write_sample();
        while (credits_free() == 0) begin
            step_cycle();
        end
        rng = xorshift32(rng);
        fifo_wr_valid = 1'b1;
        fifo_wr_data  = ds_sample_t'(rng[7:0]);
        credits_spent++;
        m_queue.push_back(rng[7:0]);
        step_cycle();
        fifo_wr_valid = 1'b0;
    endtask

    // runs between an audio_valid and the next tick
    task automatic apply_row(input test_row_t row);
        master_en    = row.master_en;
        sq_duty      = row.duty;
        sq_period    = row.period;
        sq_length    = row.length;
        sq_length_en = row.length_en;
        sq_volume    = row.volume;
        sq_env_up    = row.env_up;
        sq_env_pace  = row.env_pace;
        {pan_sq_l, pan_sq_r, pan_ds_l, pan_ds_r} = row.pan;
        ds_half      = row.ds_half;
        m_pwr        = row.master_en;
        step_cycle();
        if (row.trigger) begin
            sq_trigger = 1'b1;
            step_cycle();
            sq_trigger   = 1'b0;
            m_active     = 1'b1;
            m_step       = 3'd0;
            m_period_cnt = row.period;
            m_len        = 64 - row.length;
            m_vol        = row.volume;
            m_env_cnt    = 0;
        end
        for (int n = 0; n < row.n_wr; n++) begin
            write_sample();
        end
        if (row.pwr_down) begin
            master_en = 1'b0;
            m_pwr     = 1'b0;
            m_queue.delete();
        end
    endtask

    task automatic load_table();
        // en trig duty period length len_en volume
        // env_up pace pan{sq_l,sq_r,ds_l,ds_r} half writes pwr_down ticks
        tests[0]  = '{1'b0, 1'b0, DUTY_12, 6'd0, 6'd0, 1'b0, 4'd0,
                      1'b0, 3'd0, 4'b1111, 1'b0, 4'd0, 1'b0, 8'd12};
        tests[1]  = '{1'b1, 1'b0, DUTY_12, 6'd0, 6'd0, 1'b0, 4'd0,
                      1'b0, 3'd0, 4'b0011, 1'b0, 4'd6, 1'b0, 8'd10};
        tests[2]  = '{1'b1, 1'b0, DUTY_12, 6'd0, 6'd0, 1'b0, 4'd0,
                      1'b0, 3'd0, 4'b0010, 1'b1, 4'd8, 1'b0, 8'd10};
        tests[3]  = '{1'b1, 1'b1, DUTY_50, 6'd0, 6'd0, 1'b0, 4'd9,
                      1'b0, 3'd0, 4'b1100, 1'b0, 4'd0, 1'b0, 8'd20};
        tests[4]  = '{1'b1, 1'b1, DUTY_12, 6'd2, 6'd0, 1'b0, 4'd15,
                      1'b0, 3'd0, 4'b1000, 1'b0, 4'd0, 1'b0, 8'd30};
        tests[5]  = '{1'b1, 1'b1, DUTY_75, 6'd1, 6'd0, 1'b0, 4'd5,
                      1'b0, 3'd0, 4'b1111, 1'b1, 4'd4, 1'b0, 8'd20};
        tests[6]  = '{1'b1, 1'b1, DUTY_25, 6'd0, 6'd58, 1'b1, 4'd7,
                      1'b0, 3'd0, 4'b0100, 1'b0, 4'd0, 1'b0, 8'd60};
        tests[7]  = '{1'b1, 1'b1, DUTY_75, 6'd0, 6'd0, 1'b0, 4'd13,
                      1'b1, 3'd1, 4'b1100, 1'b0, 4'd0, 1'b0, 8'd110};
        tests[8]  = '{1'b1, 1'b1, DUTY_75, 6'd0, 6'd0, 1'b0, 4'd1,
                      1'b0, 3'd2, 4'b1100, 1'b0, 4'd0, 1'b0, 8'd140};
        tests[9]  = '{1'b1, 1'b0, DUTY_75, 6'd0, 6'd0, 1'b0, 4'd2,
                      1'b0, 3'd0, 4'b0011, 1'b0, 4'd5, 1'b1, 8'd6};
        tests[10] = '{1'b1, 1'b0, DUTY_75, 6'd0, 6'd0, 1'b0, 4'd2,
                      1'b0, 3'd0, 4'b0011, 1'b0, 4'd3, 1'b0, 8'd6};
        names = '{"powered off", "direct sound", "direct half", "duty 50",
                  "duty 12 slow", "square and ds", "length", "envelope up",
                  "envelope down", "power down", "power up again"};
    endtask

    initial begin
        arst_n        = 1'b0;
        master_en     = 1'b0;
        sq_trigger    = 1'b0;
        sq_duty       = DUTY_12;
        sq_period     = '0;
        sq_length     = '0;
        sq_length_en  = 1'b0;
        sq_volume     = '0;
        sq_env_up     = 1'b0;
        sq_env_pace   = '0;
        pan_sq_l      = 1'b0;
        pan_sq_r      = 1'b0;
        pan_ds_l      = 1'b0;
        pan_ds_r      = 1'b0;
        ds_half       = 1'b0;
        fifo_wr_valid = 1'b0;
        fifo_wr_data  = '0;
        model_clear();
        load_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk_100);
        #0.5;
        arst_n = 1'b1;
        // first sample after reset lines the model up with the DUT
        wait_valid();
        model_tick();
        check_outputs();
        for (int i = 0; i < NUM_TESTS; i++) begin
            test_errors = 0;
            apply_row(tests[i]);
            for (int t = 0; t < tests[i].n_ticks; t++) begin
                wait_valid();
                model_tick();
                check_outputs();
            end
            check_value("credits", credits_free(), `AUD_FIFO_DEPTH);
            if (test_errors != 0) begin
                failed_tests++;
            end
            $display("test %0d %s: %0d samples, %0d mismatches",
                     i, names[i], tests[i].n_ticks, test_errors);
        end
        $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = 16 + `AUD_SAMPLE_DIV * 4;
        wait (table_ready);
        for (int i = 0; i < NUM_TESTS; i++) begin
            limit += tests[i].n_ticks * `AUD_SAMPLE_DIV * 4;
        end
        repeat (limit) @(posedge clk_100);
        $display("timeout: the tests did not finish within %0d cycles", limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== verilog/audio_top.sv ====
`timescale 1ns/1ps

module audio_top (
    input  logic                   clk_100,
    input  logic                   arst_n,
    input  logic                   master_en,
    input  logic                   sq_trigger,
    input  audio_pkg::duty_e       sq_duty,
    input  logic [5:0]             sq_period,
    input  logic [5:0]             sq_length,
    input  logic                   sq_length_en,
    input  audio_pkg::sq_level_t   sq_volume,
    input  logic                   sq_env_up,
    input  logic [2:0]             sq_env_pace,
    input  logic                   pan_sq_l,
    input  logic                   pan_sq_r,
    input  logic                   pan_ds_l,
    input  logic                   pan_ds_r,
    input  logic                   ds_half,
    input  logic                   fifo_wr_valid,
    input  audio_pkg::ds_sample_t  fifo_wr_data,
    output logic                   fifo_credit,
    output audio_pkg::mix_sample_t audio_l,
    output audio_pkg::mix_sample_t audio_r,
    output logic                   audio_valid
);

    import audio_pkg::*;

    logic       chan_clear;
    logic       drain;
    logic       fifo_empty;
    logic       sq_active;
    sq_level_t  sq_level;
    ds_sample_t ds_sample;

    seq_tick_if ticks ();

    frame_sequencer u_seq (
        .clk_100 (clk_100),
        .arst_n  (arst_n),
        .ticks   (ticks)
    );

    power_ctrl u_pwr (
        .clk_100    (clk_100),
        .arst_n     (arst_n),
        .master_en  (master_en),
        .fifo_empty (fifo_empty),
        .chan_clear (chan_clear),
        .drain      (drain)
    );

    square_channel u_sq (
        .clk_100      (clk_100),
        .arst_n       (arst_n),
        .ticks        (ticks),
        .chan_clear   (chan_clear),
        .sq_trigger   (sq_trigger),
        .sq_duty      (sq_duty),
        .sq_period    (sq_period),
        .sq_length    (sq_length),
        .sq_length_en (sq_length_en),
        .sq_volume    (sq_volume),
        .sq_env_up    (sq_env_up),
        .sq_env_pace  (sq_env_pace),
        .sq_level     (sq_level),
        .sq_active    (sq_active)
    );

    direct_sound_fifo u_fifo (
        .clk_100    (clk_100),
        .arst_n     (arst_n),
        .ticks      (ticks),
        .wr_valid   (fifo_wr_valid),
        .wr_data    (fifo_wr_data),
        .chan_clear (chan_clear),
        .drain      (drain),
        .ds_sample  (ds_sample),
        .fifo_empty (fifo_empty),
        .credit     (fifo_credit)
    );

    audio_mixer u_mix (
        .clk_100     (clk_100),
        .arst_n      (arst_n),
        .ticks       (ticks),
        .sq_level    (sq_level),
        .sq_active   (sq_active),
        .ds_sample   (ds_sample),
        .pan_sq_l    (pan_sq_l),
        .pan_sq_r    (pan_sq_r),
        .pan_ds_l    (pan_ds_l),
        .pan_ds_r    (pan_ds_r),
        .ds_half     (ds_half),
        .audio_l     (audio_l),
        .audio_r     (audio_r),
        .audio_valid (audio_valid)
    );

endmodule

// ==== verilog/audio_mixer.sv ====
`timescale 1ns/1ps

module audio_mixer (
    input  logic                   clk_100,
    input  logic                   arst_n,
    seq_tick_if.user               ticks,
    input  audio_pkg::sq_level_t   sq_level,
    input  logic                   sq_active,
    input  audio_pkg::ds_sample_t  ds_sample,
    input  logic                   pan_sq_l,
    input  logic                   pan_sq_r,
    input  logic                   pan_ds_l,
    input  logic                   pan_ds_r,
    input  logic                   ds_half,
    output audio_pkg::mix_sample_t audio_l,
    output audio_pkg::mix_sample_t audio_r,
    output logic                   audio_valid
);

    import audio_pkg::*;

    mix_sample_t sq_term;
    mix_sample_t ds_term;
    mix_sample_t sum_l;
    mix_sample_t sum_r;
    logic        tick_d;

    always_comb begin
        // square level scaled by 4
        sq_term = sq_active ? mix_sample_t'({sq_level, 2'b00}) : mix_sample_t'(0);
        ds_term = ds_half ? mix_sample_t'(ds_sample >>> 1) : mix_sample_t'(ds_sample);
        sum_l   = (pan_sq_l ? sq_term : mix_sample_t'(0))
                + (pan_ds_l ? ds_term : mix_sample_t'(0));
        sum_r   = (pan_sq_r ? sq_term : mix_sample_t'(0))
                + (pan_ds_r ? ds_term : mix_sample_t'(0));
    end

    // channels settle the cycle after the tick
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            tick_d      <= 1'b0;
            audio_valid <= 1'b0;
            audio_l     <= '0;
            audio_r     <= '0;
        end else begin
            tick_d      <= ticks.sample_tick;
            audio_valid <= tick_d;
            if (tick_d) begin
                audio_l <= sum_l;
                audio_r <= sum_r;
            end
        end
    end

endmodule

// ==== verilog/direct_sound_fifo.sv ====
`timescale 1ns/1ps
`include "audio_settings.svh"

module direct_sound_fifo (
    input  logic                  clk_100,
    input  logic                  arst_n,
    seq_tick_if.user              ticks,
    input  logic                  wr_valid,
    input  audio_pkg::ds_sample_t wr_data,
    input  logic                  chan_clear,
    input  logic                  drain,
    output audio_pkg::ds_sample_t ds_sample,
    output logic                  fifo_empty,
    output logic                  credit
);

    import audio_pkg::*;

    localparam int DEPTH = `AUD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    ds_sample_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign fifo_empty = (count == '0);

    // playback on the sample tick, or one per cycle while draining
    assign pop = !fifo_empty && (drain || (ticks.sample_tick && !chan_clear));

    always_ff @(posedge clk_100) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credit    <= 1'b0;
            ds_sample <= '0;
        end else begin
            credit <= pop;
            if (wr_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_valid, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
            // last sample holds when empty
            if (chan_clear) begin
                ds_sample <= '0;
            end else if (pop) begin
                ds_sample <= mem[rd_ptr];
            end
        end
    end

endmodule

// ==== verilog/square_channel.sv ====
`timescale 1ns/1ps

module square_channel (
    input  logic                  clk_100,
    input  logic                  arst_n,
    seq_tick_if.user              ticks,
    input  logic                  chan_clear,
    input  logic                  sq_trigger,
    input  audio_pkg::duty_e      sq_duty,
    input  logic [5:0]            sq_period,
    input  logic [5:0]            sq_length,
    input  logic                  sq_length_en,
    input  audio_pkg::sq_level_t  sq_volume,
    input  logic                  sq_env_up,
    input  logic [2:0]            sq_env_pace,
    output audio_pkg::sq_level_t  sq_level,
    output logic                  sq_active
);

    import audio_pkg::*;

    logic       active;
    logic [2:0] duty_step;
    logic [5:0] period_cnt;
    logic [6:0] len_cnt;
    sq_level_t  volume;
    logic [2:0] env_cnt;
    logic       duty_high;

    always_comb begin
        case (sq_duty)
            DUTY_12: duty_high = (duty_step == 3'd7);
            DUTY_25: duty_high = (duty_step[2:1] == 2'b11);
            DUTY_50: duty_high = duty_step[2];
            DUTY_75: duty_high = (duty_step[2:1] != 2'b11);
            default: duty_high = 1'b0;
        endcase
    end

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            active     <= 1'b0;
            duty_step  <= 3'd0;
            period_cnt <= 6'd0;
            len_cnt    <= 7'd0;
            volume     <= '0;
            env_cnt    <= 3'd0;
        end else if (chan_clear) begin
            active     <= 1'b0;
            duty_step  <= 3'd0;
            period_cnt <= 6'd0;
            len_cnt    <= 7'd0;
            volume     <= '0;
            env_cnt    <= 3'd0;
        end else if (sq_trigger) begin
            active     <= 1'b1;
            duty_step  <= 3'd0;
            period_cnt <= sq_period;
            len_cnt    <= 7'd64 - {1'b0, sq_length};
            volume     <= sq_volume;
            env_cnt    <= 3'd0;
        end else begin
            // duty step moves every sq_period+1 samples
            if (ticks.sample_tick) begin
                if (period_cnt == 6'd0) begin
                    period_cnt <= sq_period;
                    duty_step  <= duty_step + 3'd1;
                end else begin
                    period_cnt <= period_cnt - 6'd1;
                end
            end
            if (ticks.length_tick && sq_length_en && active && (len_cnt != 7'd0)) begin
                len_cnt <= len_cnt - 7'd1;
                if (len_cnt == 7'd1) begin
                    active <= 1'b0;
                end
            end
            // pace of 0 freezes the envelope
            if (ticks.env_tick && (sq_env_pace != 3'd0)) begin
                if (env_cnt == sq_env_pace - 3'd1) begin
                    env_cnt <= 3'd0;
                    if (sq_env_up && (volume != 4'hf)) begin
                        volume <= volume + 4'd1;
                    end else if (!sq_env_up && (volume != 4'h0)) begin
                        volume <= volume - 4'd1;
                    end
                end else begin
                    env_cnt <= env_cnt + 3'd1;
                end
            end
        end
    end

    assign sq_level  = (active && duty_high) ? volume : '0;
    assign sq_active = active;

endmodule

// ==== verilog/power_ctrl.sv ====
`timescale 1ns/1ps

module power_ctrl (
    input  logic clk_100,
    input  logic arst_n,
    input  logic master_en,
    input  logic fifo_empty,
    output logic chan_clear,
    output logic drain
);

    import audio_pkg::*;

    power_state_e state;
    power_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            PWR_OFF: begin
                if (master_en) begin
                    state_nxt = PWR_ON;
                end
            end
            PWR_ON: begin
                if (!master_en) begin
                    state_nxt = PWR_CLEAR;
                end
            end
            PWR_CLEAR: begin
                // wait for the FIFO to give back every entry
                if (fifo_empty) begin
                    state_nxt = PWR_OFF;
                end
            end
            default: begin
                state_nxt = PWR_OFF;
            end
        endcase
    end

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            state <= PWR_OFF;
        end else begin
            state <= state_nxt;
        end
    end

    // channels held cleared unless powered
    assign chan_clear = (state != PWR_ON);
    assign drain      = (state == PWR_CLEAR);

endmodule

// ==== verilog/frame_sequencer.sv ====
`timescale 1ns/1ps
`include "audio_settings.svh"

module frame_sequencer (
    input  logic      clk_100,
    input  logic      arst_n,
    seq_tick_if.timer ticks
);

    localparam int SAMPLE_DIV   = `AUD_SAMPLE_DIV;
    localparam int STEP_SAMPLES = `AUD_STEP_SAMPLES;
    localparam int DIV_W        = $clog2(SAMPLE_DIV);
    localparam int SMP_W        = $clog2(STEP_SAMPLES);

    logic [DIV_W-1:0] div_cnt;
    logic [SMP_W-1:0] smp_cnt;
    logic             div_wrap;
    logic             smp_wrap;
    logic             step_adv;
    logic [2:0]       next_step;

    assign div_wrap  = (div_cnt == DIV_W'(SAMPLE_DIV - 1));
    assign smp_wrap  = (smp_cnt == SMP_W'(STEP_SAMPLES - 1));
    assign step_adv  = div_wrap && smp_wrap;
    assign next_step = ticks.step + 3'd1;

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt           <= '0;
            smp_cnt           <= '0;
            ticks.sample_tick <= 1'b0;
            ticks.length_tick <= 1'b0;
            ticks.env_tick    <= 1'b0;
            ticks.step        <= 3'd0;
        end else begin
            ticks.sample_tick <= div_wrap;
            // length on even steps, envelope on step 7
            ticks.length_tick <= step_adv && !next_step[0];
            ticks.env_tick    <= step_adv && (next_step == 3'd7);
            div_cnt <= div_wrap ? '0 : div_cnt + DIV_W'(1);
            if (div_wrap) begin
                smp_cnt <= smp_wrap ? '0 : smp_cnt + SMP_W'(1);
            end
            if (step_adv) begin
                ticks.step <= next_step;
            end
        end
    end

endmodule

// ==== verilog/seq_tick_if.sv ====
`timescale 1ns/1ps

interface seq_tick_if;

    logic       sample_tick;
    logic       length_tick;
    logic       env_tick;
    logic [2:0] step;

    modport timer (
        output sample_tick,
        output length_tick,
        output env_tick,
        output step
    );

    modport user (
        input sample_tick,
        input length_tick,
        input env_tick,
        input step
    );

endinterface

// ==== verilog/audio_pkg.sv ====
`include "audio_settings.svh"

package audio_pkg;

    // power control states
    typedef enum logic [1:0] {
        PWR_OFF,
        PWR_ON,
        PWR_CLEAR
    } power_state_e;

    // square wave duty cycles
    typedef enum logic [1:0] {
        DUTY_12,
        DUTY_25,
        DUTY_50,
        DUTY_75
    } duty_e;

    // direct sound sample, two's complement
    typedef logic signed [7:0] ds_sample_t;

    typedef logic [3:0] sq_level_t;

    // mixer output
    typedef logic signed [`AUD_OUT_W-1:0] mix_sample_t;

endpackage

// ==== verilog/audio_settings.svh ====
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// clock cycles per sample tick
`define AUD_SAMPLE_DIV 16

// sample ticks per sequencer step
`define AUD_STEP_SAMPLES 4

// direct sound FIFO entries, also the host's starting credits
`define AUD_FIFO_DEPTH 8

// mixed output width
`define AUD_OUT_W 10

`endif
